//--- build.f
isaPkg.sv
aluPkg.sv
mainDecoder.sv
aluDecoder.sv
alu.sv
regFile.sv
mipsExecute.sv
mipsExecute_assert.sv
mipsExecuteTb.sv

//--- Makefile
# Verilator simulation of the MIPS execute slice
VERILATOR ?= verilator
TOP       ?= mipsExecuteTb
FILELIST  ?= build.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "=== FAIL ===" $(LOG) || [ $$status -ne 0 ]; then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- mipsExecuteTb.sv
`timescale 1ns/10ps

module mipsExecuteTb;

	import isaPkg::*;
	import aluPkg::*;

	// about 90 strobes at two cycles each plus reset and slack
	localparam int cycleLimit = 8 + 90 * 2 + 100;

	logic        clk;
	logic        rstN;
	logic        instrValid;
	instrU       instr;
	retireT      retire;
	logic [31:0] shadow [numRegs];
	logic [15:0] lfsr = 16'd25;
	int          cycleCount = 0;
	int          errCount = 0;
	int          checkCount = 0;

	mipsExecute mipsExecute_inst (
		.clk        (clk),
		.rstN       (rstN),
		.instrValid (instrValid),
		.instr      (instr),
		.retire     (retire)
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	// watchdog
	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit) begin
			$display("timeout, run went past %0d cycles", cycleLimit);
			$display("=== FAIL ===");
			$finish;
		end
	end

	////////////////////////////////////////
	// stimulus helpers
	////////////////////////////////////////

	// fibonacci lfsr with taps 16 14 13 11
	// one step per bit taken
	function automatic logic [31:0] randBits(input int n);
		logic [31:0] acc;
		logic        fb;
		acc = '0;
		for (int k = 0; k < n; k++) begin
			fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr = {lfsr[14:0], fb};
			acc = {acc[30:0], fb};
		end
		return acc;
	endfunction

	// source register among r1..r8
	function automatic regIdxT pick();
		return regIdxT'(1 + randBits(3));
	endfunction

	function automatic instrU mkR(functT f, regIdxT rs, regIdxT rt, regIdxT rd, logic [4:0] sh);
		instrU w;
		w.r.opcode = opRType;
		w.r.rs = rs;
		w.r.rt = rt;
		w.r.rd = rd;
		w.r.shamt = sh;
		w.r.funct = f;
		return w;
	endfunction

	function automatic instrU mkI(opcodeT op, regIdxT rs, regIdxT rt, logic [15:0] imm);
		instrU w;
		w.i.opcode = op;
		w.i.rs = rs;
		w.i.rt = rt;
		w.i.imm = imm;
		return w;
	endfunction

	////////////////////////////////////////
	// reference model and checks
	////////////////////////////////////////

	// expected record from the shadow registers
	function automatic retireT predict(instrU w);
		retireT      e;
		logic [31:0] a;
		logic [31:0] b;
		a = shadow[w.r.rs];
		b = shadow[w.r.rt];
		e = '0;
		e.valid = 1'b1;
		e.dest = w.r.rt;
		case (w.r.opcode)
			opAddi: e.result = a + 32'($signed(w.i.imm));
			opBeq: begin
				e.result = a - b;
				e.branchTaken = (a == b);
			end
			opRType: begin
				e.dest = w.r.rd;
				case (w.r.funct)
					fnAdd:  e.result = a + b;
					fnSub:  e.result = a - b;
					fnAnd:  e.result = a & b;
					fnOr:   e.result = a | b;
					fnXor:  e.result = a ^ b;
					fnNor:  e.result = ~(a | b);
					fnMult: e.result = a * b;
					fnSlt:  e.result = {31'd0, $signed(a) < $signed(b)};
					fnSll:  e.result = b << w.r.shamt;
					fnSrl:  e.result = b >> w.r.shamt;
					fnSra:  e.result = $signed(b) >>> w.r.shamt;
					fnJr: begin
						e.result = a;
						e.isJump = 1'b1;
					end
					default: e.illegal = 1'b1;
				endcase
			end
			default: e.illegal = 1'b1;
		endcase
		// addi and plain r-type write but never to r0
		e.writeEn = (w.r.opcode == opAddi || w.r.opcode == opRType)
			&& !e.illegal && !e.isJump && (e.dest != '0);
		return e;
	endfunction

	// dest and result carry no meaning on an illegal record
	task automatic checkRetire(input string name, input retireT exp, input retireT act);
		retireT e;
		retireT g;
		e = exp;
		g = act;
		if (exp.illegal) begin
			e.dest = '0;
			e.result = '0;
			g.dest = '0;
			g.result = '0;
		end
		checkCount++;
		if (g !== e) begin
			errCount++;
			$display("** Error @ %0t: %s retire exp %h got %h", $time, name, e, g);
		end
	endtask

	task automatic checkResult(input string name, input logic [31:0] exp, input logic [31:0] act);
		checkCount++;
		if (act !== exp) begin
			errCount++;
			$display("** Error @ %0t: %s result exp %h got %h", $time, name, exp, act);
		end
	endtask

	// strobe once and wait for the record
	// then check it and update the model
	task automatic execOne(input string name, input instrU w, output retireT got);
		retireT e;
		int     waits;
		e = predict(w);
		@(posedge clk);
		instrValid <= 1'b1;
		instr <= w;
		@(posedge clk);
		instrValid <= 1'b0;
		waits = 0;
		@(negedge clk);
		while (!retire.valid && waits < 4) begin
			@(negedge clk);
			waits++;
		end
		got = retire;
		if (!got.valid) begin
			errCount++;
			$display("%s produced no retire record within 4 cycles", name);
		end else begin
			checkRetire(name, e, got);
		end
		if (e.writeEn) shadow[e.dest] = e.result;
	endtask

	// jr used as a read port that writes nothing
	task automatic probe(input regIdxT r);
		retireT got;
		execOne($sformatf("jr r%0d", r), mkR(fnJr, r, '0, '0, '0), got);
		checkResult($sformatf("r%0d", r), shadow[r], got.result);
	endtask

	////////////////////////////////////////
	// directed tests
	////////////////////////////////////////

	task automatic loadRegs();
		retireT got;
		for (int r = 1; r <= 8; r++) begin
			execOne("addi load", mkI(opAddi, '0, regIdxT'(r), 16'(randBits(16))), got);
		end
		// negative immediates exercise sign extension
		execOne("addi neg", mkI(opAddi, '0, 5'd9, 16'hff80), got);
		execOne("addi neg rs", mkI(opAddi, 5'd9, 5'd10, 16'hfffb), got);
		execOne("addi r0", mkI(opAddi, 5'd5, '0, 16'h1234), got);
		probe('0);
	endtask

	task automatic aluOps();
		retireT got;
		regIdxT rs;
		regIdxT rt;
		regIdxT rd;
		functT  ops [7] = '{fnAdd, fnSub, fnAnd, fnOr, fnXor, fnNor, fnMult};
		foreach (ops[k]) begin
			rs = pick();
			rt = pick();
			rd = regIdxT'(11 + randBits(3));
			execOne(ops[k].name(), mkR(ops[k], rs, rt, rd, '0), got);
		end
	endtask

	task automatic shiftsAndSlt();
		retireT     got;
		logic [4:0] amts [4] = '{5'd0, 5'd1, 5'd7, 5'd31};
		logic [4:0] sh;
		for (int k = 0; k < 5; k++) begin
			sh = (k < 4) ? amts[k] : 5'(randBits(5));
			execOne("sll", mkR(fnSll, '0, 5'd9, 5'd20, sh), got);
			execOne("srl", mkR(fnSrl, '0, 5'd9, 5'd21, sh), got);
			execOne("sra", mkR(fnSra, '0, 5'd9, 5'd22, sh), got);
		end
		// -128 vs -133 in both orders
		// then a negative value against r1
		execOne("slt neg pair", mkR(fnSlt, 5'd9, 5'd10, 5'd23, '0), got);
		execOne("slt swapped", mkR(fnSlt, 5'd10, 5'd9, 5'd24, '0), got);
		execOne("slt mixed sign", mkR(fnSlt, 5'd9, 5'd1, 5'd25, '0), got);
	endtask

	task automatic branchAndJump();
		retireT got;
		execOne("beq equal", mkI(opBeq, 5'd3, 5'd3, 16'h0010), got);
		execOne("beq unequal", mkI(opBeq, 5'd9, 5'd10, 16'h0010), got);
		// live rt and rd so the rs result and the blocked write both matter
		execOne("jr", mkR(fnJr, 5'd7, 5'd9, 5'd12, '0), got);
		checkResult("jr target", shadow[7], got.result);
	endtask

	task automatic illegalOps();
		retireT got;
		instrU  w;
		// lw opcode is not decoded here
		w = 32'h8c22_0004;
		execOne("bad opcode", w, got);
		// r-type rd=3 with funct 0x3f
		w = 32'h0022_183f;
		execOne("bad funct", w, got);
		for (int r = 0; r < numRegs; r++) probe(regIdxT'(r));
	endtask

	// strobe every cycle with each op reading the last dest
	task automatic backToBack();
		instrU  c [8];
		retireT pred [8];
		c[0] = mkI(opAddi, '0, 5'd26, 16'(randBits(16)));
		c[1] = mkR(fnAdd, 5'd26, 5'd26, 5'd27, '0);
		c[2] = mkR(fnSub, 5'd27, 5'd26, 5'd28, '0);
		c[3] = mkR(fnXor, 5'd28, 5'd27, 5'd29, '0);
		c[4] = mkR(fnMult, 5'd29, 5'd28, 5'd30, '0);
		c[5] = mkR(fnSll, '0, 5'd30, 5'd31, 5'd3);
		c[6] = mkR(fnSra, '0, 5'd31, 5'd26, 5'd2);
		c[7] = mkI(opAddi, 5'd26, 5'd27, 16'h8001);
		for (int k = 0; k < 8; k++) begin
			pred[k] = predict(c[k]);
			if (pred[k].writeEn) shadow[pred[k].dest] = pred[k].result;
		end
		for (int k = 0; k <= 8; k++) begin
			@(posedge clk);
			if (k < 8) begin
				instrValid <= 1'b1;
				instr <= c[k];
			end else begin
				instrValid <= 1'b0;
			end
			@(negedge clk);
			if (k > 0) checkRetire($sformatf("chain %0d", k - 1), pred[k - 1], retire);
		end
		for (int r = 26; r < 32; r++) probe(regIdxT'(r));
	endtask

	initial begin
		rstN <= 1'b0;
		instrValid <= 1'b0;
		instr <= '0;
		foreach (shadow[i]) shadow[i] = '0;
		repeat (8) @(posedge clk);
		rstN <= 1'b1;
		@(negedge clk);
		checkRetire("after reset", '0, retire);
		loadRegs();
		aluOps();
		shiftsAndSlt();
		branchAndJump();
		illegalOps();
		backToBack();
		$display("checks %0d, errors %0d", checkCount, errCount);
		if (errCount == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

//--- mipsExecute_assert.sv
`timescale 1ns/10ps

module mipsExecuteAssert (
	input logic           clk,
	input logic           rstN,
	input logic           instrValid,
	input aluPkg::retireT retire
);

	// record one edge after each strobe, and only then
	validAfterStrobe: assert property (@(posedge clk) disable iff (!rstN)
		instrValid |=> retire.valid)
		else $error("retire.valid missing one cycle after strobe");
	validOnlyAfterStrobe: assert property (@(posedge clk) disable iff (!rstN)
		retire.valid |-> $past(instrValid))
		else $error("retire.valid without a strobe the cycle before");

	// illegal records never commit
	noWriteOnIllegal: assert property (@(posedge clk) disable iff (!rstN)
		retire.writeEn |-> !retire.illegal)
		else $error("retire.writeEn set on an illegal record");

	// r0 writes are dropped before the record
	noWriteToR0: assert property (@(posedge clk) disable iff (!rstN)
		retire.writeEn |-> (retire.dest != '0))
		else $error("retire.writeEn set with dest r0");

	// whole record held clear in reset
	zeroInReset: assert property (@(posedge clk) !rstN |-> (retire == '0))
		else $error("retire not zero during reset");

endmodule

bind mipsExecute mipsExecuteAssert mipsExecuteAssert_inst (
	.clk        (clk),
	.rstN       (rstN),
	.instrValid (instrValid),
	.retire     (retire)
);

//--- mipsExecute.sv
`timescale 1ns/10ps

module mipsExecute (
	input  logic           clk,
	input  logic           rstN,
	input  logic           instrValid,
	input  isaPkg::instrU  instr,
	output aluPkg::retireT retire
);

	import isaPkg::*;
	import aluPkg::*;

	// decode results
	ctrlT        ctrl;
	aluCtrlT     aluCtrl;
	logic        unknownFunct;
	logic        isJr;
	logic        illegal;

	// operands and ALU
	logic [31:0] rdDataA;
	logic [31:0] rdDataB;
	logic [31:0] opA;
	logic [31:0] regB;
	logic [31:0] immExt;
	logic [31:0] opB;
	logic [31:0] aluResult;
	logic        aluZero;
	regIdxT      dest;
	retireT      retireNext;

	////////////////////////////////////////
	// decode
	////////////////////////////////////////

	mainDecoder mainDecoder_inst (
		.opcode (instr.r.opcode),
		.ctrl   (ctrl)
	);

	aluDecoder aluDecoder_inst (
		.aluOp        (ctrl.aluOp),
		.funct        (instr.r.funct),
		.aluCtrl      (aluCtrl),
		.unknownFunct (unknownFunct),
		.isJr         (isJr)
	);

	// bad opcode or bad funct, nothing may commit
	assign illegal = ctrl.illegalOp | unknownFunct;

	////////////////////////////////////////
	// operands
	////////////////////////////////////////

	// writeback comes from the retire register, one edge late
	regFile regFile_inst (
		.clk     (clk),
		.rstN    (rstN),
		.rdAddrA (instr.r.rs),
		.rdAddrB (instr.r.rt),
		.rdDataA (rdDataA),
		.rdDataB (rdDataB),
		.wrEn    (retire.writeEn),
		.wrAddr  (retire.dest),
		.wrData  (retire.result)
	);

	// bypass the pending write so back-to-back strobes see it
	// writeEn already excludes r0
	assign opA = (retire.writeEn && (retire.dest == instr.r.rs)) ? retire.result : rdDataA;
	assign regB = (retire.writeEn && (retire.dest == instr.r.rt)) ? retire.result : rdDataB;

	// imm read through the i-format view of the same word
	assign immExt = {{16{instr.i.imm[15]}}, instr.i.imm};
	assign opB = ctrl.useImm ? immExt : regB;

	alu alu_inst (
		.aluCtrl (aluCtrl),
		.a       (opA),
		.b       (opB),
		.shamt   (instr.r.shamt),
		.result  (aluResult),
		.zero    (aluZero)
	);

	////////////////////////////////////////
	// retire record
	////////////////////////////////////////

	// rd for r-type, rt for addi
	assign dest = ctrl.regDstRd ? instr.r.rd : instr.r.rt;

	always_comb begin
		retireNext.valid = 1'b1;
		// jr and illegal never write, r0 writes are dropped
		retireNext.writeEn = ctrl.regWrite & ~illegal & ~isJr & (dest != '0);
		retireNext.dest = dest;
		// jr reports the jump target held in rs
		retireNext.result = isJr ? opA : aluResult;
		retireNext.branchTaken = ctrl.isBranch & aluZero;
		retireNext.isJump = isJr & ~illegal;
		retireNext.illegal = illegal;
	end

	// one-cycle record, zero between strobes
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			retire <= '0;
		end else begin
			retire <= instrValid ? retireNext : '0;
		end
	end

endmodule

//--- regFile.sv
`timescale 1ns/10ps

module regFile (
	input  logic           clk,
	input  logic           rstN,
	input  isaPkg::regIdxT rdAddrA,
	input  isaPkg::regIdxT rdAddrB,
	output logic [31:0]    rdDataA,
	output logic [31:0]    rdDataB,
	input  logic           wrEn,
	input  isaPkg::regIdxT wrAddr,
	input  logic [31:0]    wrData
);

	import isaPkg::*;

	// register storage
	logic [31:0] regs [numRegs];

	////////////////////////////////////////
	// write port
	////////////////////////////////////////

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			// whole file comes up zero
			for (int i = 0; i < numRegs; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn && (wrAddr != '0)) begin
			// r0 never takes a write
			regs[wrAddr] <= wrData;
		end
	end

	////////////////////////////////////////
	// read ports
	////////////////////////////////////////

	// asynchronous, r0 hardwired to zero
	assign rdDataA = (rdAddrA == '0) ? '0 : regs[rdAddrA];
	assign rdDataB = (rdAddrB == '0) ? '0 : regs[rdAddrB];

endmodule

//--- alu.sv
`timescale 1ns/10ps

module alu (
	input  aluPkg::aluCtrlT aluCtrl,
	input  logic [31:0]     a,
	input  logic [31:0]     b,
	input  logic [4:0]      shamt,
	output logic [31:0]     result,
	output logic            zero
);

	import aluPkg::*;

	////////////////////////////////////////
	// operation select
	////////////////////////////////////////

	always_comb begin
		case (aluCtrl)
			// bitwise logic
			aluAnd: result = a & b;
			aluOr:  result = a | b;
			aluXor: result = a ^ b;
			aluNor: result = ~(a | b);

			// signed less-than gives 1 or 0
			aluSlt: result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;

			// shifts move b as MIPS does
			aluSll: result = b << shamt;
			aluSrl: result = b >> shamt;
			aluSra: result = $unsigned($signed(b) >>> shamt);

			// arithmetic
			aluAdd: result = a + b;
			aluSub: result = a - b;
			// product truncated to the low word
			aluMul: result = a * b;

			default: result = '0;
		endcase
	end

	// beq looks at this after the sub
	assign zero = (result == '0);

endmodule

//--- aluDecoder.sv
`timescale 1ns/10ps

module aluDecoder (
	input  aluPkg::aluOpT   aluOp,
	input  isaPkg::functT   funct,
	output aluPkg::aluCtrlT aluCtrl,
	output logic            unknownFunct,
	output logic            isJr
);

	import isaPkg::*;
	import aluPkg::*;

	always_comb begin
		// defaults keep every path assigned
		aluCtrl      = aluAdd;
		unknownFunct = 1'b0;
		isJr         = 1'b0;

		// forced add, addi path
		if (aluOp == aluOpAdd) begin
			aluCtrl = aluAdd;
		end

		// forced sub, beq compare
		else if (aluOp == aluOpSub) begin
			aluCtrl = aluSub;
		end

		// r-type, funct picks the op
		else if (aluOp == aluOpRType) begin
			case (funct)
				fnMult: aluCtrl = aluMul;
				fnAdd:  aluCtrl = aluAdd;
				fnSub:  aluCtrl = aluSub;
				fnAnd:  aluCtrl = aluAnd;
				fnOr:   aluCtrl = aluOr;
				fnXor:  aluCtrl = aluXor;
				fnNor:  aluCtrl = aluNor;
				fnSlt:  aluCtrl = aluSlt;
				fnSll:  aluCtrl = aluSll;
				fnSrl:  aluCtrl = aluSrl;
				fnSra:  aluCtrl = aluSra;
				// jr runs as add, top forwards rs
				fnJr: begin
					aluCtrl = aluAdd;
					isJr    = 1'b1;
				end
				// unlisted funct, harmless add plus flag
				default: begin
					aluCtrl      = aluAdd;
					unknownFunct = 1'b1;
				end
			endcase
		end
	end

endmodule

//--- mainDecoder.sv
`timescale 1ns/10ps

module mainDecoder (
	input  isaPkg::opcodeT opcode,
	output aluPkg::ctrlT   ctrl
);

	import isaPkg::*;
	import aluPkg::*;

	////////////////////////////////////////
	// opcode decode
	////////////////////////////////////////

	always_comb begin
		// everything off unless the opcode says otherwise
		ctrl = '0;

		case (opcode)
			// register format
			// writes rd, ALU op comes from funct
			opRType: begin
				ctrl.regWrite = 1'b1;
				ctrl.regDstRd = 1'b1;
				ctrl.aluOp    = aluOpRType;
			end

			// addi
			// rs plus sign-extended imm into rt
			opAddi: begin
				ctrl.regWrite = 1'b1;
				ctrl.useImm   = 1'b1;
				ctrl.aluOp    = aluOpAdd;
			end

			// beq
			// subtract to compare, no writeback
			opBeq: begin
				ctrl.isBranch = 1'b1;
				ctrl.aluOp    = aluOpSub;
			end

			// unsupported opcode
			// flag it, leave all enables low
			default: begin
				ctrl.illegalOp = 1'b1;
			end
		endcase
	end

endmodule

//--- aluPkg.sv
package aluPkg;

	////////////////////////////////////////
	// decoder to ALU encodings
	////////////////////////////////////////

	// operation class from the main decoder
	// add for addi, sub for beq, rType defers to funct
	typedef enum logic [1:0] {
		aluOpAdd   = 2'b00,
		aluOpSub   = 2'b01,
		aluOpRType = 2'b10
	} aluOpT;

	// ALU control code
	// gaps at 9 and 10 are unused
	typedef enum logic [3:0] {
		aluAnd = 4'd0,
		aluOr  = 4'd1,
		aluXor = 4'd2,
		aluNor = 4'd3,
		aluSlt = 4'd4,
		aluSll = 4'd5,
		aluSrl = 4'd6,
		aluAdd = 4'd7,
		aluSub = 4'd8,
		aluSra = 4'd11,
		aluMul = 4'd12
	} aluCtrlT;

	////////////////////////////////////////
	// control and retire records
	////////////////////////////////////////

	// main decoder outputs
	typedef struct packed {
		logic  regWrite;
		logic  useImm;
		logic  regDstRd;
		logic  isBranch;
		aluOpT aluOp;
		logic  illegalOp;
	} ctrlT;

	// one record per executed instruction
	typedef struct packed {
		logic           valid;
		logic           writeEn;
		isaPkg::regIdxT dest;
		logic [31:0]    result;
		logic           branchTaken;
		logic           isJump;
		logic           illegal;
	} retireT;

endpackage

//--- isaPkg.sv
package isaPkg;

	////////////////////////////////////////
	// register file geometry
	////////////////////////////////////////

	// architectural register count
	localparam int numRegs = 32;

	// register index, sized from the count
	typedef logic [$clog2(numRegs)-1:0] regIdxT;

	////////////////////////////////////////
	// opcode and function encodings
	////////////////////////////////////////

	// opcodes executed by this slice
	// anything else decodes as illegal
	typedef enum logic [5:0] {
		opRType = 6'b000000,
		opBeq   = 6'b000100,
		opAddi  = 6'b001000
	} opcodeT;

	// r-type function codes, standard MIPS values
	typedef enum logic [5:0] {
		fnSll  = 6'b000000,
		fnSrl  = 6'b000010,
		fnSra  = 6'b000011,
		fnJr   = 6'b001000,
		fnMult = 6'b011000,
		fnAdd  = 6'b100000,
		fnSub  = 6'b100010,
		fnAnd  = 6'b100100,
		fnOr   = 6'b100101,
		fnXor  = 6'b100110,
		fnNor  = 6'b100111,
		fnSlt  = 6'b101010
	} functT;

	////////////////////////////////////////
	// instruction formats
	////////////////////////////////////////

	// register format, msb first
	typedef struct packed {
		opcodeT     opcode;
		regIdxT     rs;
		regIdxT     rt;
		regIdxT     rd;
		logic [4:0] shamt;
		functT      funct;
	} rFormatT;

	// immediate format
	// low 16 bits overlay rd, shamt and funct
	typedef struct packed {
		opcodeT      opcode;
		regIdxT      rs;
		regIdxT      rt;
		logic [15:0] imm;
	} iFormatT;

	// one word, read through either view
	typedef union packed {
		rFormatT r;
		iFormatT i;
	} instrU;

endpackage
